//--- Makefile
TOP = fetch_frontend_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -j 0 --top-module $(TOP) -f fetch_frontend.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- dv/fetch_frontend_tb.sv
/*
  fetch front end testbench
  replays stimulus records from the input file and checks every fetch block
*/
`timescale 1ns/1ps

module fetch_frontend_tb import fetch_pkg::*; ();

  localparam int TIMEOUT = 200;   // cycles per wait
  localparam int QUIET   = 40;

  logic         clk = 1'b0;
  logic         rst;
  logic         credit_return;
  logic         irq_valid;
  ip_t          irq_ip;
  logic         ret_valid;
  ip_t          ret_src_ip;
  ip_t          ret_target;
  logic         ret_taken;
  branch_kind_e ret_kind;
  logic         ret_mispredict;
  ght_t         ret_ght;
  logic         fetch_valid;
  ip_t          fetch_ip;
  ght_t         fetch_ght;
  logic         fetch_taken;

  logic [44:0]  fetch_q [$];   // history and taken flag above the ip
  logic [31:0]  fld [9];
  branch_kind_e learned [logic [27:0]];   // kinds of taken retired branches per half block
  ght_t         exp_ght = '0;
  int           checks = 0;
  int           errors = 0;
  int           tests = 0;
  int           err_mark = 0;
  int           seen = 0;
  int           returned = 0;
  bit           aborted = 1'b0;
  string        test_name;

  fetch_frontend fetch_frontend_i (.*);

  always #10 clk = ~clk;

  // collect fetch blocks and track credits in flight
  always @(posedge clk) begin
    if (!rst) begin
      if (credit_return) begin
        returned++;
      end
      if (fetch_valid) begin
        fetch_q.push_back({fetch_ght, fetch_taken, fetch_ip});
        seen++;
      end
      if (seen - returned > CREDITS) begin
        $display("%0t: %0d fetches outstanding, more than the credit limit", $time,
                 seen - returned);
        errors++;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // a learned conditional in either slot shifts the history
  function automatic bit block_has_cond(input ip_t blk_ip);
    logic [27:0] key;
    for (int s = 0; s < 2; s++) begin
      key = {blk_ip[31:5], s[0]};
      if (learned.exists(key) && learned[key] == br_cond) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic give_credits(input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      credit_return <= 1'b1;
      @(posedge clk);
      credit_return <= 1'b0;
    end
  endtask

  task automatic expect_fetch(input logic [31:0] exp_ip, input logic exp_taken);
    int          n;
    logic [44:0] blk;
    n = 0;
    while (fetch_q.size() == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (fetch_q.size() == 0) begin
      $display("%0t: no fetch block within %0d cycles, ip %h was due", $time, TIMEOUT,
               exp_ip);
      errors++;
      aborted = 1'b1;
    end else begin
      blk = fetch_q.pop_front();
      check_value("fetch_ip", blk[31:0], exp_ip);
      check_value("fetch_taken", 32'(blk[32]), 32'(exp_taken));
      check_value("fetch_ght", 32'(blk[44:33]), 32'(exp_ght));
      if (block_has_cond(exp_ip)) begin
        exp_ght = {exp_ght[GHT_W-2:0], exp_taken};
      end
    end
  endtask

  // credits are out, nothing may arrive
  task automatic expect_quiet();
    for (int n = 0; n < QUIET; n++) begin
      @(negedge clk);
    end
    checks++;
    if (fetch_q.size() != 0) begin
      $display("%0t: fetch of ip %h arrived with no credit left", $time, fetch_q[0][31:0]);
      errors++;
      fetch_q.delete();
    end
  endtask

  // one cycle of irq and retire inputs
  task automatic apply_event();
    @(posedge clk);
    irq_valid      <= fld[0][0];
    irq_ip         <= fld[1];
    ret_valid      <= fld[2][0];
    ret_src_ip     <= fld[3];
    ret_target     <= fld[4];
    ret_taken      <= fld[5][0];
    ret_kind       <= branch_kind_e'(fld[6][1:0]);
    ret_mispredict <= fld[7][0];
    ret_ght        <= fld[8][GHT_W-1:0];
    if (fld[2][0] && fld[5][0]) begin
      learned[fld[3][31:4]] = branch_kind_e'(fld[6][1:0]);
    end
    if (!fld[0][0] && fld[2][0] && fld[7][0]) begin
      exp_ght = {fld[8][GHT_W-2:0], fld[5][0]};   // irq keeps the history
    end
    @(posedge clk);
    irq_valid <= 1'b0;
    ret_valid <= 1'b0;
  endtask

  task automatic close_test();
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests, test_name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, test_name, errors - err_mark);
    end
  endtask

  initial begin
    int    fd;
    string line;
    string op;
    void'($urandom(32'h7020));
    rst            = 1'b1;
    credit_return  = 1'b0;
    irq_valid      = 1'b0;
    irq_ip         = '0;
    ret_valid      = 1'b0;
    ret_src_ip     = '0;
    ret_target     = '0;
    ret_taken      = 1'b0;
    ret_kind       = br_cond;
    ret_mispredict = 1'b0;
    ret_ght        = '0;
    fd = $fopen("dv/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file dv/fetch_input.txt");
      errors++;
      aborted = 1'b1;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (!aborted && $fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.getc(0) == "#" || $sscanf(line, "%s", op) != 1) begin
        continue;
      end
      if (op == "T" && $sscanf(line, "%s %s", op, test_name) == 2) begin
        if (tests > 0) begin
          close_test();
        end
        tests++;
        err_mark = errors;
      end else if (op == "C" && $sscanf(line, "%s %h", op, fld[0]) == 2) begin
        give_credits(fld[0]);
      end else if (op == "F" && $sscanf(line, "%s %h %h", op, fld[0], fld[1]) == 3) begin
        expect_fetch(fld[0], fld[1][0]);
      end else if (op == "Q") begin
        expect_quiet();
      end else if (op == "E" && $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", op, fld[0],
                 fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]) == 10) begin
        apply_event();
      end else begin
        $display("stimulus record not understood: %s", line);
        errors++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (tests > 0) begin
      close_test();
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- dv/fetch_input.txt
# T name | C credits | F ip taken | Q (no fetch while credits are out)
# E irq_v irq_ip ret_v src target taken kind misp ght, hex; kind 0 cond 1 jump 2 call 3 ret
T reset_credits
F 00001000 0
F 00001020 0
F 00001040 0
F 00001060 0
Q
T credit_resume
C 4
F 00001080 0
F 000010a0 0
F 000010c0 0
F 000010e0 0
T jump_learn
E 0 00000000 1 00001100 00001400 1 1 1 000
C 1
F 00001400 0
E 1 00001100 0 00000000 00000000 0 0 0 000
C 2
F 00001100 1
F 00001400 0
T cond_learn
E 0 00000000 1 00003000 00002000 1 1 1 000
C 1
F 00002000 0
E 0 00000000 1 00002010 00002800 1 0 1 001
C 1
F 00002800 0
E 0 00000000 1 00003000 00002000 1 1 1 000
C 2
F 00002000 1
F 00002800 0
T call_return
E 0 00000000 1 00004040 00005000 1 2 1 000
E 0 00000000 1 00005020 00006000 1 3 1 000
E 1 00004040 0 00000000 00000000 0 0 0 000
C 3
F 00004040 1
F 00005000 0
F 00005020 1
C 1
F 00004060 0
T irq_priority
E 1 00007000 0 00000000 00000000 0 0 0 000
C 1
F 00007000 0
E 1 00007400 1 00001100 00001400 1 1 1 000
C 1
F 00007400 0

//--- fetch_frontend.f
hw/fetch_pkg.sv
hw/frontend_ifs.sv
hw/branch_target_buffer.sv
hw/direction_predictor.sv
hw/return_stack.sv
hw/fetch_sequencer.sv
hw/fetch_frontend.sv
dv/fetch_frontend_tb.sv

//--- hw/branch_target_buffer.sv
/*
  branch target buffer, 64 sets of two tagged slots
  combinational lookup by fetch ip, written by taken retired branches
*/
`timescale 1ns/1ps

module branch_target_buffer import fetch_pkg::*; (
  input logic       clk,
  input logic       rst,
  predict_if.btb    lk,
  retire_if.btb     up
);

  logic [1:0]           valid_q  [BTB_SETS];
  logic [BTB_TAG_W-1:0] tag_q    [BTB_SETS][2];
  branch_kind_e         kind_q   [BTB_SETS][2];
  ip_t                  target_q [BTB_SETS][2];

  logic [BTB_IDX_W-1:0] rd_set;
  logic [BTB_TAG_W-1:0] rd_tag;
  logic [BTB_IDX_W-1:0] wr_set;
  logic [BTB_TAG_W-1:0] wr_tag;
  logic                 wr_slot;
  logic                 wr_en;

  assign rd_set = lk.ip[OFFSET_W +: BTB_IDX_W];
  assign rd_tag = lk.ip[ADDR_W-1 -: BTB_TAG_W];

  assign wr_set  = up.src_ip[OFFSET_W +: BTB_IDX_W];
  assign wr_tag  = up.src_ip[ADDR_W-1 -: BTB_TAG_W];
  assign wr_slot = up.src_ip[OFFSET_W-1];   // lower or upper half of the block
  assign wr_en   = up.upd_valid && up.taken;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      lk.slot_hit[s]    = valid_q[rd_set][s] && (tag_q[rd_set][s] == rd_tag);
      lk.slot_kind[s]   = kind_q[rd_set][s];
      lk.slot_target[s] = target_q[rd_set][s];
    end
  end

  // only the valid bits are control state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_SETS; i++) begin
        valid_q[i] <= '0;
      end
    end else if (wr_en) begin
      valid_q[wr_set][wr_slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_set][wr_slot]    <= wr_tag;
      kind_q[wr_set][wr_slot]   <= up.kind;
      target_q[wr_set][wr_slot] <= up.target;
    end
  end

endmodule

//--- hw/direction_predictor.sv
/*
  direction predictor, three tables xor-combined per slot
  mispredicted conditionals toggle A always, B every 4th and C every 16th time
*/
`timescale 1ns/1ps

module direction_predictor import fetch_pkg::*; (
  input logic       clk,
  input logic       rst,
  predict_if.dir    lk,
  retire_if.dir     up
);

  logic [1:0] tab_a [PRED_ENTRIES];
  logic [1:0] tab_b [PRED_ENTRIES];
  logic [1:0] tab_c [PRED_ENTRIES];

  logic [MISS_CNT_W-1:0] miss_cnt;

  logic [PRED_IDX_W-1:0] rd_a, rd_b, rd_c;
  logic [PRED_IDX_W-1:0] wr_a, wr_b, wr_c;
  logic [1:0]            wr_mask;
  logic                  wr_en;

  // ip bits 10:5 with history 1:0
  function automatic logic [PRED_IDX_W-1:0] idx_a(ip_t ip, ght_t g);
    return {ip[10:5], g[1:0]};
  endfunction

  // ip bits 7:5 with history 4:0
  function automatic logic [PRED_IDX_W-1:0] idx_b(ip_t ip, ght_t g);
    return {ip[7:5], g[4:0]};
  endfunction

  // history only
  function automatic logic [PRED_IDX_W-1:0] idx_c(ght_t g);
    return g[7:0];
  endfunction

  assign rd_a = idx_a(lk.ip, lk.ght);
  assign rd_b = idx_b(lk.ip, lk.ght);
  assign rd_c = idx_c(lk.ght);

  assign lk.slot_dir = tab_a[rd_a] ^ tab_b[rd_b] ^ tab_c[rd_c];

  assign wr_a    = idx_a(up.src_ip, up.ght);
  assign wr_b    = idx_b(up.src_ip, up.ght);
  assign wr_c    = idx_c(up.ght);
  assign wr_mask = up.src_ip[OFFSET_W-1] ? 2'b10 : 2'b01;
  assign wr_en   = up.upd_valid && up.mispredict && (up.kind == br_cond);

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_cnt <= '0;
      for (int i = 0; i < PRED_ENTRIES; i++) begin
        tab_a[i] <= '0;
        tab_b[i] <= '0;
        tab_c[i] <= '0;
      end
    end else if (wr_en) begin
      tab_a[wr_a] <= tab_a[wr_a] ^ wr_mask;
      if (miss_cnt[1:0] == '0) begin
        tab_b[wr_b] <= tab_b[wr_b] ^ wr_mask;
      end
      if (miss_cnt == '0) begin
        tab_c[wr_c] <= tab_c[wr_c] ^ wr_mask;
      end
      miss_cnt <= miss_cnt + 1'b1;   // wraps, keeps the 4/16 cadence
    end
  end

endmodule

//--- hw/fetch_frontend.sv
/*
  fetch front end top
  sequencer with target buffer, direction tables and return stack
*/
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         credit_return,
  input  logic         irq_valid,
  input  ip_t          irq_ip,
  input  logic         ret_valid,
  input  ip_t          ret_src_ip,
  input  ip_t          ret_target,
  input  logic         ret_taken,
  input  branch_kind_e ret_kind,
  input  logic         ret_mispredict,
  input  ght_t         ret_ght,
  output logic         fetch_valid,
  output ip_t          fetch_ip,
  output ght_t         fetch_ght,
  output logic         fetch_taken
);

  predict_if lk_bus ();
  retire_if  up_bus ();

  logic ras_push;
  logic ras_pop;
  ip_t  ras_push_addr;

  fetch_sequencer seq_i (
    .clk            (clk),
    .rst            (rst),
    .lk             (lk_bus.seq),
    .up             (up_bus.seq),
    .ras_push       (ras_push),
    .ras_pop        (ras_pop),
    .ras_push_addr  (ras_push_addr),
    .credit_return  (credit_return),
    .irq_valid      (irq_valid),
    .irq_ip         (irq_ip),
    .ret_valid      (ret_valid),
    .ret_src_ip     (ret_src_ip),
    .ret_target     (ret_target),
    .ret_taken      (ret_taken),
    .ret_kind       (ret_kind),
    .ret_mispredict (ret_mispredict),
    .ret_ght        (ret_ght),
    .fetch_valid    (fetch_valid),
    .fetch_ip       (fetch_ip),
    .fetch_ght      (fetch_ght),
    .fetch_taken    (fetch_taken)
  );

  branch_target_buffer btb_i (
    .clk (clk),
    .rst (rst),
    .lk  (lk_bus.btb),
    .up  (up_bus.btb)
  );

  direction_predictor dir_i (
    .clk (clk),
    .rst (rst),
    .lk  (lk_bus.dir),
    .up  (up_bus.dir)
  );

  return_stack ras_i (
    .clk       (clk),
    .rst       (rst),
    .lk        (lk_bus.ras),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr)
  );

endmodule

//--- hw/fetch_pkg.sv
/*
  fetch front end package
  widths, table sizes, reset vector, credit count and shared enums
*/
package fetch_pkg;

  // address and fetch block
  localparam int ADDR_W      = 32;
  localparam int BLOCK_BYTES = 32;
  localparam int OFFSET_W    = $clog2(BLOCK_BYTES);   // byte offset inside a block

  // global history
  localparam int GHT_W = 12;

  // direction tables, one bit per slot in each entry
  localparam int PRED_IDX_W   = 8;
  localparam int PRED_ENTRIES = 1 << PRED_IDX_W;
  localparam int MISS_CNT_W   = 4;   // wraps at 16

  // target buffer
  localparam int BTB_SETS  = 64;
  localparam int BTB_IDX_W = $clog2(BTB_SETS);
  localparam int BTB_TAG_W = ADDR_W - BTB_IDX_W - OFFSET_W;

  // return stack
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_W = $clog2(RAS_DEPTH);

  // credit flow control toward the instruction fetch side
  localparam int CREDITS  = 4;
  localparam int CREDIT_W = $clog2(CREDITS + 1);

  localparam logic [ADDR_W-1:0] RESET_IP = 32'h0000_1000;

  typedef logic [ADDR_W-1:0] ip_t;
  typedef logic [GHT_W-1:0]  ght_t;

  typedef enum logic [1:0] {
    br_cond,
    br_jump,
    br_call,
    br_ret
  } branch_kind_e;

  // which source loads the ip on the next edge
  typedef enum logic [2:0] {
    src_seq,
    src_predicted,
    src_retire,
    src_irq
  } next_src_e;

endpackage

//--- hw/fetch_sequencer.sv
/*
  fetch sequencer: ip, history and credit registers
  picks the next ip from irq, retire redirect, prediction or sequential step
*/
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  predict_if.seq       lk,
  retire_if.seq        up,
  output logic         ras_push,
  output logic         ras_pop,
  output ip_t          ras_push_addr,
  input  logic         credit_return,
  input  logic         irq_valid,
  input  ip_t          irq_ip,
  input  logic         ret_valid,
  input  ip_t          ret_src_ip,
  input  ip_t          ret_target,
  input  logic         ret_taken,
  input  branch_kind_e ret_kind,
  input  logic         ret_mispredict,
  input  ght_t         ret_ght,
  output logic         fetch_valid,
  output ip_t          fetch_ip,
  output ght_t         fetch_ght,
  output logic         fetch_taken
);

  ip_t                 ip_q;
  ght_t                ght_q;
  logic [CREDIT_W-1:0] credits_q;

  logic [1:0]   slot_taken;
  logic         sel;
  logic         pred_taken;
  branch_kind_e pred_kind;
  ip_t          pred_target;
  logic         cond_hit;
  ght_t         pred_ght;
  logic         redirect;
  ip_t          redirect_ip;
  ght_t         redirect_ght;
  logic         issue;
  next_src_e    next_src;

  assign lk.ip  = ip_q;
  assign lk.ght = ght_q;

  // retire port straight onto the update bus
  assign up.upd_valid  = ret_valid;
  assign up.src_ip     = ret_src_ip;
  assign up.target     = ret_target;
  assign up.taken      = ret_taken;
  assign up.kind       = ret_kind;
  assign up.mispredict = ret_mispredict;
  assign up.ght        = ret_ght;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      slot_taken[s] = lk.slot_hit[s] && ((lk.slot_kind[s] != br_cond) || lk.slot_dir[s]);
    end
  end

  assign sel         = !slot_taken[0];   // slot 0 first
  assign pred_taken  = |slot_taken;
  assign pred_kind   = lk.slot_kind[sel];
  assign pred_target = (pred_kind == br_ret) ? lk.ras_top : lk.slot_target[sel];
  assign cond_hit    = (lk.slot_hit[0] && lk.slot_kind[0] == br_cond) ||
                       (lk.slot_hit[1] && lk.slot_kind[1] == br_cond);
  assign pred_ght    = cond_hit ? {ght_q[GHT_W-2:0], pred_taken} : ght_q;

  assign redirect     = ret_valid && ret_mispredict;
  assign redirect_ip  = ret_taken ? ret_target
                                  : (ret_src_ip & ~ip_t'(BLOCK_BYTES - 1)) + BLOCK_BYTES;
  assign redirect_ght = {ret_ght[GHT_W-2:0], ret_taken};

  assign issue = !irq_valid && !redirect && (credits_q != '0);

  assign ras_push      = issue && pred_taken && (pred_kind == br_call);
  assign ras_pop       = issue && pred_taken && (pred_kind == br_ret);
  assign ras_push_addr = ip_q + BLOCK_BYTES;

  always_comb begin
    if (irq_valid)       next_src = src_irq;
    else if (redirect)   next_src = src_retire;
    else if (pred_taken) next_src = src_predicted;
    else                 next_src = src_seq;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q        <= RESET_IP;
      ght_q       <= '0;
      credits_q   <= CREDITS[CREDIT_W-1:0];
      fetch_valid <= 1'b0;
    end else begin
      credits_q   <= credits_q - CREDIT_W'(issue) + CREDIT_W'(credit_return);
      fetch_valid <= issue;
      case (next_src)
        src_irq:    ip_q <= irq_ip;   // history kept
        src_retire: begin
          ip_q  <= redirect_ip;
          ght_q <= redirect_ght;
        end
        src_predicted: if (issue) begin
          ip_q  <= pred_target;
          ght_q <= pred_ght;
        end
        default: if (issue) begin
          ip_q  <= ip_q + BLOCK_BYTES;
          ght_q <= pred_ght;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      fetch_ip    <= ip_q;
      fetch_ght   <= ght_q;   // history the block was predicted with
      fetch_taken <= pred_taken;
    end
  end

endmodule

//--- hw/frontend_ifs.sv
/*
  front end interfaces
  predict_if carries the same-cycle lookup, retire_if the retirement update
*/
`timescale 1ns/1ps

interface predict_if import fetch_pkg::*; ();

  ip_t          ip;
  ght_t         ght;
  logic [1:0]   slot_hit;
  branch_kind_e slot_kind [2];
  ip_t          slot_target [2];
  logic [1:0]   slot_dir;   // xor of the three direction tables
  ip_t          ras_top;

  modport seq (
    output ip, ght,
    input  slot_hit, slot_kind, slot_target, slot_dir, ras_top
  );

  modport btb (input ip, output slot_hit, slot_kind, slot_target);

  modport dir (input ip, ght, output slot_dir);

  modport ras (output ras_top);

endinterface

// consumed in the cycle upd_valid is high, no handshake
interface retire_if import fetch_pkg::*; ();

  logic         upd_valid;
  ip_t          src_ip;
  ip_t          target;
  logic         taken;
  branch_kind_e kind;
  logic         mispredict;
  ght_t         ght;   // history the branch was predicted with

  modport seq (output upd_valid, src_ip, target, taken, kind, mispredict, ght);

  modport btb (input upd_valid, src_ip, target, taken, kind);

  modport dir (input upd_valid, src_ip, kind, mispredict, ght);

endinterface

//--- hw/return_stack.sv
/*
  return address stack, circular with a wrapping pointer
  top entry feeds predicted returns in the same cycle
*/
`timescale 1ns/1ps

module return_stack import fetch_pkg::*; (
  input logic       clk,
  input logic       rst,
  predict_if.ras    lk,
  input logic       push,
  input logic       pop,
  input ip_t        push_addr
);

  ip_t                  stack_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] ptr_q;
  logic [RAS_PTR_W-1:0] ptr_inc;

  assign ptr_inc    = ptr_q + 1'b1;   // overflow overwrites the oldest entry
  assign lk.ras_top = stack_q[ptr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_inc;
    end else if (pop) begin
      ptr_q <= ptr_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_q[ptr_inc] <= push_addr;
    end
  end

endmodule
